//--- eth_demux_cfg.svh
// Ethernet demux configuration
// port count and field widths shared by the package, RTL and testbench

`ifndef ETH_DEMUX_CFG_SVH
`define ETH_DEMUX_CFG_SVH

// number of output ports
`define ETH_NUM_PORTS 4

// payload datapath
`define ETH_DATA_W 64
`define ETH_KEEP_W (`ETH_DATA_W / 8)

// header fields
`define ETH_MAC_W 48
`define ETH_TYPE_W 16

`endif

//--- eth_demux_pkg.sv
// Ethernet demux types
// header and payload beat structs, port index and frame state

`include "eth_demux_cfg.svh"

package eth_demux_pkg;

    // frame header, 112 bits with the default widths
    typedef struct packed {
        logic [`ETH_MAC_W-1:0]  dest_mac;
        logic [`ETH_MAC_W-1:0]  src_mac;
        logic [`ETH_TYPE_W-1:0] eth_type;
    } eth_hdr_t;

    // one payload beat with byte enables and end of frame
    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        logic [`ETH_KEEP_W-1:0] keep;
        logic                   last;
    } eth_beat_t;

    typedef logic [$clog2(`ETH_NUM_PORTS)-1:0] port_sel_t;

    typedef enum logic [0:0] {
        FRAME_IDLE = 1'b0,
        FRAME_BODY = 1'b1
    } frame_state_e;

endpackage

//--- eth_frame_ctrl.sv
// Ethernet demux frame controller
// samples the port select at frame start, captures the header and
// raises the header valid of the chosen port

`include "eth_demux_cfg.svh"

module eth_frame_ctrl
    import eth_demux_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      enable,
    input  port_sel_t                 select,

    // header input
    input  eth_hdr_t                  s_hdr,
    input  logic                      s_hdr_valid,
    output logic                      s_hdr_ready,

    // header outputs, data shared by all ports
    output eth_hdr_t                  m_hdr,
    output logic [`ETH_NUM_PORTS-1:0] m_hdr_valid,
    input  logic [`ETH_NUM_PORTS-1:0] m_hdr_ready,

    // payload path status and control
    input  logic [`ETH_NUM_PORTS-1:0] m_beat_valid,
    input  logic                      last_taken,
    output port_sel_t                 sel,
    output logic                      frame_open
);

    frame_state_e              state;
    frame_state_e              state_next;
    logic                      frame_start;
    logic                      hdr_ready_next;
    logic [`ETH_NUM_PORTS-1:0] hdr_valid_next;

    always_comb begin
        // the shared output registers must be drained on the port in use
        frame_start = (state == FRAME_IDLE) && enable && s_hdr_valid &&
                      !m_hdr_valid[sel] && !m_beat_valid[sel];

        state_next = state;
        if (last_taken) begin
            state_next = FRAME_IDLE;
        end
        if (frame_start) begin
            state_next = FRAME_BODY;
        end

        // payload ready opens on the same edge as the header handshake
        frame_open = (state_next == FRAME_BODY);

        // header valid drops once the selected port takes it
        hdr_valid_next = m_hdr_valid & ~m_hdr_ready;
        if (frame_start) begin
            hdr_valid_next[select] = 1'b1;
        end

        // one cycle ready pulse, valid is held by the source
        hdr_ready_next = frame_start;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= FRAME_IDLE;
            sel         <= '0;
            s_hdr_ready <= 1'b0;
            m_hdr_valid <= '0;
        end else begin
            state       <= state_next;
            s_hdr_ready <= hdr_ready_next;
            m_hdr_valid <= hdr_valid_next;
            if (frame_start) begin
                sel <= select;
            end
        end
    end

    // header capture
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_hdr <= s_hdr;
        end
    end

endmodule

//--- eth_payload_skid.sv
// Ethernet demux payload path
// one-beat skid buffer that steers beats to the selected port

`include "eth_demux_cfg.svh"

module eth_payload_skid
    import eth_demux_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // frame control
    input  port_sel_t                 sel,
    input  logic                      frame_open,
    output logic                      last_taken,

    // payload input
    input  eth_beat_t                 s_beat,
    input  logic                      s_beat_valid,
    output logic                      s_beat_ready,

    // payload outputs, data shared by all ports
    output eth_beat_t                 m_beat,
    output logic [`ETH_NUM_PORTS-1:0] m_beat_valid,
    input  logic [`ETH_NUM_PORTS-1:0] m_beat_ready
);

    eth_beat_t                 temp_beat;
    logic                      temp_valid;
    logic                      temp_valid_next;
    logic [`ETH_NUM_PORTS-1:0] beat_valid_next;
    logic [`ETH_NUM_PORTS-1:0] sel_onehot;
    logic                      beat_taken;
    logic                      cur_valid;
    logic                      cur_ready;
    logic                      ready_early;
    logic                      in_to_out;
    logic                      in_to_temp;
    logic                      temp_to_out;

    assign sel_onehot = `ETH_NUM_PORTS'(1) << sel;
    assign cur_valid  = m_beat_valid[sel];
    assign cur_ready  = m_beat_ready[sel];
    assign beat_taken = s_beat_valid && s_beat_ready;
    assign last_taken = beat_taken && s_beat.last;

    // accept next cycle if the output drains or the temp slot stays free
    assign ready_early = cur_ready || (!temp_valid && (!cur_valid || !beat_taken));

    always_comb begin
        beat_valid_next = m_beat_valid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;

        if (s_beat_ready) begin
            if (cur_ready || !cur_valid) begin
                // output free, beat goes straight out
                beat_valid_next = beat_taken ? sel_onehot : '0;
                in_to_out       = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = beat_taken;
                in_to_temp      = 1'b1;
            end
        end else if (cur_ready) begin
            // input held off, drain the temp slot
            beat_valid_next = temp_valid ? sel_onehot : '0;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_beat_ready <= 1'b0;
            m_beat_valid <= '0;
            temp_valid   <= 1'b0;
        end else begin
            s_beat_ready <= ready_early && frame_open;
            m_beat_valid <= beat_valid_next;
            temp_valid   <= temp_valid_next;
        end
    end

    // beat registers
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_beat <= s_beat;
        end else if (temp_to_out) begin
            m_beat <= temp_beat;
        end

        if (in_to_temp) begin
            temp_beat <= s_beat;
        end
    end

endmodule

//--- eth_demux.sv
// Ethernet frame demultiplexer, 64-bit datapath
// routes each frame to the port selected at its start

`include "eth_demux_cfg.svh"

module eth_demux
    import eth_demux_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // frame input
    input  eth_hdr_t                  s_hdr,
    input  logic                      s_hdr_valid,
    output logic                      s_hdr_ready,
    input  eth_beat_t                 s_beat,
    input  logic                      s_beat_valid,
    output logic                      s_beat_ready,

    // frame outputs, one valid and ready bit per port
    output eth_hdr_t                  m_hdr,
    output logic [`ETH_NUM_PORTS-1:0] m_hdr_valid,
    input  logic [`ETH_NUM_PORTS-1:0] m_hdr_ready,
    output eth_beat_t                 m_beat,
    output logic [`ETH_NUM_PORTS-1:0] m_beat_valid,
    input  logic [`ETH_NUM_PORTS-1:0] m_beat_ready,

    // control
    input  logic                      enable,
    input  port_sel_t                 select
);

    port_sel_t sel;
    logic      frame_open;
    logic      last_taken;

    eth_frame_ctrl u_frame_ctrl (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .select       (select),
        .s_hdr        (s_hdr),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .m_hdr        (m_hdr),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_beat_valid (m_beat_valid),
        .last_taken   (last_taken),
        .sel          (sel),
        .frame_open   (frame_open)
    );

    // payload follows the port latched by the frame controller
    eth_payload_skid u_payload_skid (
        .clk          (clk),
        .rst          (rst),
        .sel          (sel),
        .frame_open   (frame_open),
        .last_taken   (last_taken),
        .s_beat       (s_beat),
        .s_beat_valid (s_beat_valid),
        .s_beat_ready (s_beat_ready),
        .m_beat       (m_beat),
        .m_beat_valid (m_beat_valid),
        .m_beat_ready (m_beat_ready)
    );

endmodule

//--- tb_eth_demux_assertions.sv
// Ethernet demux assertions
// one-hot output valids, stable payload under back-pressure, reset values

`include "eth_demux_cfg.svh"

module tb_eth_demux_assertions
    import eth_demux_pkg::*;
(
    input logic                      clk,
    input logic                      rst,
    input logic                      s_hdr_ready,
    input logic                      s_beat_ready,
    input logic [`ETH_NUM_PORTS-1:0] m_hdr_valid,
    input logic [`ETH_NUM_PORTS-1:0] m_beat_valid,
    input logic [`ETH_NUM_PORTS-1:0] m_beat_ready,
    input eth_beat_t                 m_beat
);
    timeunit 1ns;
    timeprecision 1ps;

    hdr_valid_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m_hdr_valid))
        else $error("more than one m_hdr_valid bit is high");

    beat_valid_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m_beat_valid))
        else $error("more than one m_beat_valid bit is high");

    // stalled beat must hold
    beat_stable: assert property (@(posedge clk) disable iff (rst)
        |(m_beat_valid & ~m_beat_ready) |=> $stable(m_beat))
        else $error("m_beat changed while stalled");

    reset_values: assert property (@(posedge clk)
        rst |=> (!s_hdr_ready && !s_beat_ready && m_hdr_valid == '0 && m_beat_valid == '0))
        else $error("valid or ready output high after reset");

endmodule

bind eth_demux tb_eth_demux_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .s_hdr_ready  (s_hdr_ready),
    .s_beat_ready (s_beat_ready),
    .m_hdr_valid  (m_hdr_valid),
    .m_beat_valid (m_beat_valid),
    .m_beat_ready (m_beat_ready),
    .m_beat       (m_beat)
);

//--- tb_eth_demux.sv
// Ethernet demux testbench
// drives random frames under per-port back-pressure and checks them against a reference model

`include "eth_demux_cfg.svh"

module tb_eth_demux
    import eth_demux_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES     = 40;
    localparam int MAX_BEATS      = 8;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_BEATS + 4) * 4;
    localparam int DRAIN_CYCLES   = 200;
    localparam int SETTLE_CYCLES  = 16;

    // one stimulus frame with n_beats payload beats
    typedef struct packed {
        port_sel_t                              port;
        logic [3:0]                             n_beats;
        eth_hdr_t                               hdr;
        logic [MAX_BEATS-1:0][`ETH_DATA_W-1:0]  data;
        logic [MAX_BEATS-1:0][`ETH_KEEP_W-1:0]  keep;
    } frame_t;

    logic                      clk;
    logic                      rst;
    eth_hdr_t                  s_hdr;
    logic                      s_hdr_valid;
    logic                      s_hdr_ready;
    eth_beat_t                 s_beat;
    logic                      s_beat_valid;
    logic                      s_beat_ready;
    eth_hdr_t                  m_hdr;
    logic [`ETH_NUM_PORTS-1:0] m_hdr_valid;
    logic [`ETH_NUM_PORTS-1:0] m_hdr_ready;
    eth_beat_t                 m_beat;
    logic [`ETH_NUM_PORTS-1:0] m_beat_valid;
    logic [`ETH_NUM_PORTS-1:0] m_beat_ready;
    logic                      enable;
    port_sel_t                 select;
    logic                      ready_random;
    int                        cycle_count;

    // expected items per output port
    eth_hdr_t  exp_hdr_q [`ETH_NUM_PORTS][$];
    eth_beat_t exp_beat_q [`ETH_NUM_PORTS][$];

    eth_demux i_eth_demux (
        .clk          (clk),
        .rst          (rst),
        .s_hdr        (s_hdr),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_beat       (s_beat),
        .s_beat_valid (s_beat_valid),
        .s_beat_ready (s_beat_ready),
        .m_hdr        (m_hdr),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_beat       (m_beat),
        .m_beat_valid (m_beat_valid),
        .m_beat_ready (m_beat_ready),
        .enable       (enable),
        .select       (select)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // a frame leaves on the port selected when its header was taken
    function automatic port_sel_t expected_frame(input frame_t f, output eth_hdr_t hdr,
                                                 output eth_beat_t [MAX_BEATS-1:0] beats);
        beats = '0;
        hdr   = f.hdr;
        for (int i = 0; i < int'(f.n_beats); i++) begin
            beats[i].data = f.data[i];
            beats[i].keep = f.keep[i];
            beats[i].last = (i == int'(f.n_beats) - 1);
        end
        return f.port;
    endfunction

    function automatic frame_t build_frame();
        frame_t       f;
        logic [127:0] r;
        r         = {$urandom, $urandom, $urandom, $urandom};
        f.hdr     = r[111:0];
        f.port    = port_sel_t'($urandom % `ETH_NUM_PORTS);
        f.n_beats = 4'(1 + $urandom % MAX_BEATS);
        for (int i = 0; i < MAX_BEATS; i++) begin
            f.data[i] = {$urandom, $urandom};
            f.keep[i] = '1;
        end
        // partial last word
        f.keep[int'(f.n_beats) - 1] = {`ETH_KEEP_W{1'b1}} >> ($urandom % `ETH_KEEP_W);
        return f;
    endfunction

    function automatic logic [`ETH_NUM_PORTS-1:0] random_ready();
        logic [`ETH_NUM_PORTS-1:0] r;
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            r[p] = ($urandom % 4) != 0;
        end
        return r;
    endfunction

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
            if (exp_hdr_q[p].size() != 0 || exp_beat_q[p].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic send_header(input frame_t f);
        s_hdr       <= f.hdr;
        select      <= f.port;
        s_hdr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_hdr_ready);
        s_hdr_valid <= 1'b0;
    endtask

    task automatic send_beat(input eth_beat_t b);
        s_beat       <= b;
        s_beat_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_beat_ready);
    endtask

    // header waits while enable is low and nothing may start
    task automatic hold_enable_low(input frame_t f);
        enable      <= 1'b0;
        s_hdr       <= f.hdr;
        select      <= f.port;
        s_hdr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (m_hdr_valid != '0 || m_beat_valid != '0);
        repeat (12) begin
            @(posedge clk);
            check_value("s_hdr_ready", 128'(s_hdr_ready), 128'(0));
            check_value("m_hdr_valid", 128'(m_hdr_valid), 128'(0));
            check_value("m_beat_valid", 128'(m_beat_valid), 128'(0));
        end
        enable <= 1'b1;
    endtask

    // random per-port back-pressure
    initial begin
        m_hdr_ready  = '0;
        m_beat_ready = '0;
        forever begin
            @(posedge clk);
            if (ready_random) begin
                m_hdr_ready  <= random_ready();
                m_beat_ready <= random_ready();
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                stop_run($sformatf("timeout: traffic did not finish in %0d cycles",
                                   TIMEOUT_CYCLES));
            end
        end
    end

    // output monitor that pops one item per handshake
    always @(posedge clk) begin
        port_sel_t ps;
        if (!rst) begin
            for (int p = 0; p < `ETH_NUM_PORTS; p++) begin
                ps = port_sel_t'(p);
                if (m_hdr_valid[ps] && m_hdr_ready[ps]) begin
                    if (exp_hdr_q[p].size() == 0) begin
                        stop_run($sformatf("unexpected header on port %0d", p));
                    end else begin
                        check_value($sformatf("m_hdr[%0d]", p), 128'(m_hdr),
                                    128'(exp_hdr_q[p].pop_front()));
                    end
                end
                if (m_beat_valid[ps] && m_beat_ready[ps]) begin
                    if (exp_beat_q[p].size() == 0) begin
                        stop_run($sformatf("unexpected payload beat on port %0d", p));
                    end else begin
                        check_value($sformatf("m_beat[%0d]", p), 128'(m_beat),
                                    128'(exp_beat_q[p].pop_front()));
                    end
                end
            end
        end
    end

    initial begin
        frame_t                    frm;
        eth_hdr_t                  hdr;
        eth_beat_t [MAX_BEATS-1:0] beats;
        eth_beat_t                 beat;
        port_sel_t                 port;
        int                        drain;

        void'($urandom(58));
        rst          = 1'b1;
        enable       = 1'b0;
        select       = '0;
        s_hdr        = '0;
        s_hdr_valid  = 1'b0;
        s_beat       = '0;
        s_beat_valid = 1'b0;
        ready_random = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        repeat (6) begin
            @(posedge clk);
            check_value("s_hdr_ready", 128'(s_hdr_ready), 128'(0));
            check_value("s_beat_ready", 128'(s_beat_ready), 128'(0));
            check_value("m_hdr_valid", 128'(m_hdr_valid), 128'(0));
            check_value("m_beat_valid", 128'(m_beat_valid), 128'(0));
        end
        enable       <= 1'b1;
        ready_random <= 1'b1;

        for (int n = 0; n < NUM_FRAMES; n++) begin
            frm  = build_frame();
            port = expected_frame(frm, hdr, beats);
            exp_hdr_q[port].push_back(hdr);
            for (int i = 0; i < int'(frm.n_beats); i++) begin
                exp_beat_q[port].push_back(beats[i]);
            end
            if (n % 10 == 5) begin
                hold_enable_low(frm);
            end
            send_header(frm);
            for (int i = 0; i < int'(frm.n_beats); i++) begin
                beat.data = frm.data[i];
                beat.keep = frm.keep[i];
                beat.last = (i == int'(frm.n_beats) - 1);
                // select moves mid-frame and routing must not follow it
                if ($urandom % 3 == 0) begin
                    select <= port_sel_t'($urandom % `ETH_NUM_PORTS);
                end
                send_beat(beat);
            end
            s_beat_valid <= 1'b0;
        end

        drain = 0;
        while (!queues_empty() && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        // a repeated item after the last expected one shows up as unexpected
        repeat (SETTLE_CYCLES) @(negedge clk);
        if (queues_empty()) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_run("expected items were never delivered");
        end
    end

endmodule

//--- verilog.f
+incdir+.
eth_demux_pkg.sv
eth_frame_ctrl.sv
eth_payload_skid.sv
eth_demux.sv
tb_eth_demux_assertions.sv
tb_eth_demux.sv

//--- Makefile
# Verilator build and run for the Ethernet demux testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module tb_eth_demux -o tb_eth_demux

run: compile
	@out="$$(./obj_dir/tb_eth_demux)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
